/* src/pipe_config.svh */
`ifndef PIPE_CONFIG_SVH
`define PIPE_CONFIG_SVH

// datapath word and load address width
`define PIPE_XLEN   32

// rv32e sized register file
`define PIPE_NREGS  16
`define PIPE_RIDX_W 4   // log2 of PIPE_NREGS

`endif

/* src/pipe_pkg.sv */
`default_nettype none

`include "pipe_config.svh"

package pipe_pkg;

    typedef logic [`PIPE_XLEN-1:0]   word_t;
    typedef logic [`PIPE_RIDX_W-1:0] reg_idx_t;  // x0 reads as zero

    // operand source picked in decode
    typedef enum logic [1:0] {
        FWD_NONE = 2'b00,  // regfile or write-through
        FWD_EX   = 2'b01,  // alu output of EX
        FWD_MEM  = 2'b10   // alu result or load data in MEM
    } fwd_sel_t;

    typedef enum logic [2:0] {
        OP_ADD  = 3'd0,
        OP_SUB  = 3'd1,
        OP_AND  = 3'd2,
        OP_OR   = 3'd3,
        OP_XOR  = 3'd4,
        OP_SLL  = 3'd5,
        OP_LOAD = 3'd6   // rd <= mem[rs1 + imm/rs2]
    } alu_op_t;

    // four-phase bus master
    typedef enum logic [1:0] {
        LP_IDLE    = 2'd0,
        LP_REQ     = 2'd1,  // req high, waiting for ack
        LP_RELEASE = 2'd2   // req dropped, waiting for ack low
    } lp_state_t;

    typedef struct packed {
        alu_op_t  op;
        reg_idx_t rd;
        reg_idx_t rs1;
        reg_idx_t rs2;
        logic     use_imm;  // operand b from imm, rs2 unused
        word_t    imm;
    } uop_t;  // 48 bits

    typedef struct packed {
        alu_op_t  op;
        reg_idx_t rd;
        word_t    operand_a;
        word_t    operand_b;
    } ex_ctl_t;

    typedef struct packed {
        logic     is_load;
        reg_idx_t rd;
        word_t    result;  // alu value or load address
    } mem_ctl_t;

    typedef struct packed {
        reg_idx_t rd;
        word_t    value;
    } retire_t;

endpackage

`default_nettype wire

/* src/hazard_unit.sv */
`default_nettype none

module hazard_unit (
    input  wire                      clk,
    input  wire                      rst_n,
    input  wire                      id_valid,
    input  wire pipe_pkg::uop_t      id_uop,
    input  wire                      ex_valid,
    input  wire pipe_pkg::ex_ctl_t   ex_ctl,
    input  wire                      mem_valid,
    input  wire pipe_pkg::mem_ctl_t  mem_ctl,
    input  wire                      load_busy,
    output pipe_pkg::fwd_sel_t       forward_a,
    output pipe_pkg::fwd_sel_t       forward_b,
    output logic                     stall_id
);

    logic ex_live;      // EX writes a real register
    logic mem_live;
    logic ex_is_load;   // value not known before MEM
    logic mem_wait;     // load in MEM without data yet
    logic stall_a;
    logic stall_b;

    assign ex_live    = id_valid && ex_valid && (ex_ctl.rd != '0);
    assign mem_live   = id_valid && mem_valid && (mem_ctl.rd != '0);
    assign ex_is_load = (ex_ctl.op == pipe_pkg::OP_LOAD);
    assign mem_wait   = mem_ctl.is_load && load_busy;

    // one source operand, EX match wins over MEM
    function automatic logic resolve(
        input  pipe_pkg::reg_idx_t src,
        input  logic               used,
        output pipe_pkg::fwd_sel_t fwd
    );
        logic ex_hit;
        logic mem_hit;
        ex_hit  = used && ex_live && (ex_ctl.rd == src);
        mem_hit = used && mem_live && (mem_ctl.rd == src);
        fwd     = pipe_pkg::FWD_NONE;
        resolve = 1'b0;
        if (ex_hit) begin
            if (ex_is_load) begin
                resolve = 1'b1;  // load-use, one bubble
            end else begin
                fwd = pipe_pkg::FWD_EX;
            end
        end else if (mem_hit) begin
            if (mem_wait) begin
                resolve = 1'b1;  // hold until data captured
            end else begin
                fwd = pipe_pkg::FWD_MEM;
            end
        end
    endfunction

    always_comb begin
        stall_a  = resolve(id_uop.rs1, 1'b1, forward_a);            // rs1 always read
        stall_b  = resolve(id_uop.rs2, !id_uop.use_imm, forward_b);
        stall_id = stall_a || stall_b;
    end

    // no stall without a uop waiting in decode
    a_stall_needs_id: assert property (@(posedge clk) disable iff (!rst_n)
        !id_valid |-> !stall_id);

    // a load result never comes from the EX adder
    a_no_ex_fwd_load: assert property (@(posedge clk) disable iff (!rst_n)
        ex_valid && (ex_ctl.op == pipe_pkg::OP_LOAD) |-> forward_a != pipe_pkg::FWD_EX);

endmodule

`default_nettype wire

/* src/pipe_control.sv */
`default_nettype none

module pipe_control (
    input  wire                      clk,
    input  wire                      rst_n,
    input  wire                      in_valid,
    input  wire pipe_pkg::uop_t      in_uop,
    input  wire                      load_busy,
    input  wire pipe_pkg::ex_ctl_t   ex_ctl,
    input  wire pipe_pkg::mem_ctl_t  mem_ctl,
    output logic                     in_ready,
    output logic                     id_advance,
    output logic                     ex_valid,
    output logic                     mem_valid,
    output logic                     ex_advance,
    output logic                     mem_advance,
    output pipe_pkg::fwd_sel_t       forward_a,
    output pipe_pkg::fwd_sel_t       forward_b
);

    logic stall_id;
    logic run_q;     // low in reset, keeps in_ready down
    logic ex_free;   // EX empty or moving on this edge

    hazard_unit u_hazard (
        .clk       (clk),
        .rst_n     (rst_n),
        .id_valid  (in_valid),   // decode works straight off the input
        .id_uop    (in_uop),
        .ex_valid  (ex_valid),
        .ex_ctl    (ex_ctl),
        .mem_valid (mem_valid),
        .mem_ctl   (mem_ctl),
        .load_busy (load_busy),
        .forward_a (forward_a),
        .forward_b (forward_b),
        .stall_id  (stall_id)
    );

    // writeback never pushes back, only a busy load holds MEM
    assign mem_advance = mem_valid && !load_busy;
    assign ex_advance  = !mem_valid || mem_advance;
    assign ex_free     = !ex_valid || ex_advance;

    assign in_ready   = run_q && ex_free && !stall_id;
    assign id_advance = in_valid && in_ready;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            run_q     <= 1'b0;
            ex_valid  <= 1'b0;
            mem_valid <= 1'b0;
        end else begin
            run_q <= 1'b1;
            if (ex_free) begin
                ex_valid <= id_advance;  // bubble on stall
            end
            if (ex_advance) begin
                mem_valid <= ex_valid;
            end
        end
    end

    // a busy load may not be dropped from MEM
    a_load_holds_mem: assert property (@(posedge clk) disable iff (!rst_n)
        mem_valid && load_busy |=> mem_valid);

endmodule

`default_nettype wire

/* src/operand_fetch.sv */
`default_nettype none

`include "pipe_config.svh"

module operand_fetch (
    input  wire                      clk,
    input  wire                      rst_n,
    input  wire pipe_pkg::uop_t      in_uop,
    input  wire                      id_advance,
    input  wire pipe_pkg::fwd_sel_t  forward_a,
    input  wire pipe_pkg::fwd_sel_t  forward_b,
    input  wire pipe_pkg::word_t     ex_fwd_value,
    input  wire pipe_pkg::word_t     mem_fwd_value,
    input  wire                      wb_valid,
    input  wire pipe_pkg::retire_t   wb,
    output pipe_pkg::ex_ctl_t        ex_ctl
);

    pipe_pkg::word_t rf [`PIPE_NREGS];
    pipe_pkg::word_t opnd_a;
    pipe_pkg::word_t opnd_b;

    // x0 hardwired, same-cycle writeback passed through
    function automatic pipe_pkg::word_t rf_read(input pipe_pkg::reg_idx_t idx);
        if (idx == '0) begin
            rf_read = '0;
        end else if (wb_valid && (wb.rd == idx)) begin
            rf_read = wb.value;
        end else begin
            rf_read = rf[idx];
        end
    endfunction

    function automatic pipe_pkg::word_t fwd_mux(
        input pipe_pkg::fwd_sel_t sel,
        input pipe_pkg::word_t    rf_val
    );
        case (sel)
            pipe_pkg::FWD_EX:  fwd_mux = ex_fwd_value;
            pipe_pkg::FWD_MEM: fwd_mux = mem_fwd_value;
            default:           fwd_mux = rf_val;
        endcase
    endfunction

    always_comb begin
        opnd_a = fwd_mux(forward_a, rf_read(in_uop.rs1));
        opnd_b = in_uop.use_imm ? in_uop.imm : fwd_mux(forward_b, rf_read(in_uop.rs2));
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `PIPE_NREGS; i++) begin
                rf[i] <= '0;
            end
        end else if (wb_valid && (wb.rd != '0)) begin
            rf[wb.rd] <= wb.value;  // x0 never written
        end
    end

    // ID/EX register
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ex_ctl <= '0;
        end else if (id_advance) begin
            ex_ctl.op        <= in_uop.op;
            ex_ctl.rd        <= in_uop.rd;
            ex_ctl.operand_a <= opnd_a;
            ex_ctl.operand_b <= opnd_b;
        end
    end

endmodule

`default_nettype wire

/* src/exec_alu.sv */
`default_nettype none

module exec_alu (
    input  wire                      clk,
    input  wire                      rst_n,
    input  wire pipe_pkg::ex_ctl_t   ex_ctl,
    input  wire                      ex_advance,
    output pipe_pkg::word_t          ex_fwd_value,
    output pipe_pkg::mem_ctl_t       mem_ctl
);

    pipe_pkg::word_t alu_out;

    always_comb begin
        case (ex_ctl.op)
            pipe_pkg::OP_ADD,
            pipe_pkg::OP_LOAD: alu_out = ex_ctl.operand_a + ex_ctl.operand_b;  // load addr
            pipe_pkg::OP_SUB:  alu_out = ex_ctl.operand_a - ex_ctl.operand_b;
            pipe_pkg::OP_AND:  alu_out = ex_ctl.operand_a & ex_ctl.operand_b;
            pipe_pkg::OP_OR:   alu_out = ex_ctl.operand_a | ex_ctl.operand_b;
            pipe_pkg::OP_XOR:  alu_out = ex_ctl.operand_a ^ ex_ctl.operand_b;
            pipe_pkg::OP_SLL:  alu_out = ex_ctl.operand_a << ex_ctl.operand_b[4:0];
            default:           alu_out = '0;
        endcase
    end

    // meaningless for loads, hazard unit never picks it then
    assign ex_fwd_value = alu_out;

    // EX/MEM register
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mem_ctl <= '0;
        end else if (ex_advance) begin
            mem_ctl.is_load <= (ex_ctl.op == pipe_pkg::OP_LOAD);
            mem_ctl.rd      <= ex_ctl.rd;
            mem_ctl.result  <= alu_out;
        end
    end

endmodule

`default_nettype wire

/* src/load_port.sv */
`default_nettype none

module load_port (
    input  wire                      clk,
    input  wire                      rst_n,
    input  wire pipe_pkg::mem_ctl_t  mem_ctl,
    input  wire                      mem_valid,
    input  wire                      mem_ack,
    input  wire pipe_pkg::word_t     mem_rdata,
    output logic                     mem_req,
    output pipe_pkg::word_t          mem_addr,
    output logic                     load_busy,
    output pipe_pkg::word_t          mem_fwd_value,
    output logic                     wb_valid,
    output pipe_pkg::retire_t        wb
);

    pipe_pkg::lp_state_t state;
    pipe_pkg::lp_state_t state_nx;
    logic                load_done;  // data captured last edge
    logic                retire;
    pipe_pkg::word_t     rdata_q;

    assign load_busy     = mem_valid && mem_ctl.is_load && !load_done;
    assign mem_req       = (state == pipe_pkg::LP_REQ);
    assign mem_fwd_value = mem_ctl.is_load ? rdata_q : mem_ctl.result;
    assign retire        = mem_valid && !load_busy;

    always_comb begin
        state_nx = state;
        case (state)
            pipe_pkg::LP_IDLE:    if (load_busy && !mem_ack) state_nx = pipe_pkg::LP_REQ;
            pipe_pkg::LP_REQ:     if (mem_ack) state_nx = pipe_pkg::LP_RELEASE;
            pipe_pkg::LP_RELEASE: if (!mem_ack) state_nx = pipe_pkg::LP_IDLE;  // phase 4
            default:              state_nx = pipe_pkg::LP_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= pipe_pkg::LP_IDLE;
            load_done <= 1'b0;
            wb_valid  <= 1'b0;
        end else begin
            state     <= state_nx;
            load_done <= mem_req && mem_ack;  // one cycle pulse as MEM then leaves
            wb_valid  <= retire;
        end
    end

    always_ff @(posedge clk) begin
        if ((state == pipe_pkg::LP_IDLE) && (state_nx == pipe_pkg::LP_REQ)) begin
            mem_addr <= mem_ctl.result;  // held for whole req phase
        end
        if (mem_req && mem_ack) begin
            rdata_q <= mem_rdata;
        end
        if (retire) begin
            wb.rd    <= mem_ctl.rd;  // MEM/WB record
            wb.value <= mem_fwd_value;
        end
    end

    // req held with a steady address until ack
    a_req_stable: assert property (@(posedge clk) disable iff (!rst_n)
        mem_req && !mem_ack |=> mem_req && $stable(mem_addr));

endmodule

`default_nettype wire

/* src/pipe_top.sv */
`default_nettype none

module pipe_top (
    input  wire                      clk,
    input  wire                      rst_n,
    input  wire pipe_pkg::uop_t      in_uop,
    input  wire                      in_valid,
    output logic                     in_ready,
    output logic                     mem_req,
    output pipe_pkg::word_t          mem_addr,
    input  wire                      mem_ack,
    input  wire pipe_pkg::word_t     mem_rdata,
    output logic                     wb_valid,
    output pipe_pkg::retire_t        wb
);

    logic                id_advance;
    logic                ex_valid;
    logic                mem_valid;
    logic                ex_advance;
    logic                load_busy;
    pipe_pkg::fwd_sel_t  forward_a;
    pipe_pkg::fwd_sel_t  forward_b;
    pipe_pkg::ex_ctl_t   ex_ctl;
    pipe_pkg::mem_ctl_t  mem_ctl;
    pipe_pkg::word_t     ex_fwd_value;
    pipe_pkg::word_t     mem_fwd_value;

    pipe_control u_control (
        .clk         (clk),
        .rst_n       (rst_n),
        .in_valid    (in_valid),
        .in_uop      (in_uop),
        .load_busy   (load_busy),
        .ex_ctl      (ex_ctl),
        .mem_ctl     (mem_ctl),
        .in_ready    (in_ready),
        .id_advance  (id_advance),
        .ex_valid    (ex_valid),
        .mem_valid   (mem_valid),
        .ex_advance  (ex_advance),
        .mem_advance (),            // used inside control only
        .forward_a   (forward_a),
        .forward_b   (forward_b)
    );

    operand_fetch u_fetch (
        .clk           (clk),
        .rst_n         (rst_n),
        .in_uop        (in_uop),
        .id_advance    (id_advance),
        .forward_a     (forward_a),
        .forward_b     (forward_b),
        .ex_fwd_value  (ex_fwd_value),
        .mem_fwd_value (mem_fwd_value),
        .wb_valid      (wb_valid),   // regfile write port
        .wb            (wb),
        .ex_ctl        (ex_ctl)
    );

    exec_alu u_alu (
        .clk          (clk),
        .rst_n        (rst_n),
        .ex_ctl       (ex_ctl),
        .ex_advance   (ex_advance),
        .ex_fwd_value (ex_fwd_value),
        .mem_ctl      (mem_ctl)
    );

    load_port u_load (
        .clk           (clk),
        .rst_n         (rst_n),
        .mem_ctl       (mem_ctl),
        .mem_valid     (mem_valid),
        .mem_ack       (mem_ack),
        .mem_rdata     (mem_rdata),
        .mem_req       (mem_req),
        .mem_addr      (mem_addr),
        .load_busy     (load_busy),
        .mem_fwd_value (mem_fwd_value),
        .wb_valid      (wb_valid),
        .wb            (wb)
    );

endmodule

`default_nettype wire

/* test/pipe_checker.sv */
`default_nettype none

`include "pipe_config.svh"

module pipe_checker (
    input  wire                      clk,
    input  wire                      rst_n,
    input  wire                      in_valid,
    input  wire                      in_ready,
    input  wire pipe_pkg::uop_t      in_uop,
    input  wire                      mem_req,
    input  wire pipe_pkg::word_t     mem_addr,
    input  wire                      mem_ack,
    input  wire                      wb_valid,
    input  wire pipe_pkg::retire_t   wb,
    output int                       accepted,
    output int                       retired,
    output int                       value_errors,
    output int                       proto_errors
);

    localparam int ALU_LATENCY = 3;  // accept edge to the edge that samples wb_valid

    pipe_pkg::word_t   model_rf [`PIPE_NREGS];  // architectural state in program order
    pipe_pkg::retire_t exp_q [$];
    int                stamp_q [$];    // cycle of acceptance
    bit                timed_q [$];    // latency fixed, nothing slow ahead
    bit                load_q [$];
    pipe_pkg::word_t   addr_q [$];     // load addresses in issue order
    int                cycle;
    int                loads_pending;  // accepted but not yet retired
    logic              prev_req;
    logic              prev_ack;
    pipe_pkg::word_t   prev_addr;

    // expected result of one micro-op, load data is the inverted address
    function automatic pipe_pkg::word_t ref_result(
        input pipe_pkg::alu_op_t op,
        input pipe_pkg::word_t   a,
        input pipe_pkg::word_t   b
    );
        case (op)
            pipe_pkg::OP_ADD:  ref_result = a + b;
            pipe_pkg::OP_SUB:  ref_result = a - b;
            pipe_pkg::OP_AND:  ref_result = a & b;
            pipe_pkg::OP_OR:   ref_result = a | b;
            pipe_pkg::OP_XOR:  ref_result = a ^ b;
            pipe_pkg::OP_SLL:  ref_result = a << b[4:0];  // shamt from low 5 bits
            pipe_pkg::OP_LOAD: ref_result = ~(a + b);
            default:           ref_result = '0;
        endcase
    endfunction

    always @(posedge clk or negedge rst_n) begin : compare
        pipe_pkg::word_t   op_a;
        pipe_pkg::word_t   op_b;
        pipe_pkg::word_t   exp_addr;
        pipe_pkg::retire_t exp;
        int                stamp;
        bit                timed;
        if (!rst_n) begin
            for (int i = 0; i < `PIPE_NREGS; i++) begin
                model_rf[i] = '0;
            end
            exp_q.delete();
            stamp_q.delete();
            timed_q.delete();
            load_q.delete();
            addr_q.delete();
            cycle         = 0;
            loads_pending = 0;
            accepted      = 0;
            retired       = 0;
            value_errors  = 0;
            proto_errors  = 0;
            prev_req      = 1'b0;
            prev_ack      = 1'b0;
            prev_addr     = '0;
        end else begin
            cycle++;
            // retire first, a load leaving frees the pipe for this edge's accept
            if (wb_valid) begin
                retired++;
                if (exp_q.size() == 0) begin
                    $display("writeback to x%0d with no micro-op outstanding", wb.rd);
                    value_errors++;
                end else begin
                    exp   = exp_q.pop_front();
                    stamp = stamp_q.pop_front();
                    timed = timed_q.pop_front();
                    if (load_q.pop_front()) begin
                        loads_pending--;
                    end
                    if (wb.rd !== exp.rd) begin
                        $display("[FAIL] wb.rd exp 0x%h got 0x%h", exp.rd, wb.rd);
                        value_errors++;
                    end
                    if (wb.value !== exp.value) begin
                        $display("[FAIL] wb.value exp 0x%h got 0x%h", exp.value, wb.value);
                        value_errors++;
                    end
                    if (timed && (cycle - stamp != ALU_LATENCY)) begin
                        $display("[FAIL] wb_valid latency exp 0x%h got 0x%h",
                                 ALU_LATENCY, cycle - stamp);
                        value_errors++;
                    end
                end
            end
            if (in_valid && in_ready) begin
                accepted++;
                op_a      = model_rf[in_uop.rs1];
                op_b      = in_uop.use_imm ? in_uop.imm : model_rf[in_uop.rs2];
                exp.rd    = in_uop.rd;
                exp.value = ref_result(in_uop.op, op_a, op_b);
                exp_q.push_back(exp);
                stamp_q.push_back(cycle);
                timed_q.push_back((loads_pending == 0) && (in_uop.op != pipe_pkg::OP_LOAD));
                load_q.push_back(in_uop.op == pipe_pkg::OP_LOAD);
                if (in_uop.op == pipe_pkg::OP_LOAD) begin
                    addr_q.push_back(op_a + op_b);
                    loads_pending++;
                end
                if (in_uop.rd != '0) begin
                    model_rf[in_uop.rd] = exp.value;  // x0 stays zero
                end
            end
            // four-phase order, prev_* is the state at the last edge
            if (mem_req && !prev_req) begin
                if (prev_ack) begin
                    $display("bus request raised while mem_ack was still high");
                    proto_errors++;
                end
                if (addr_q.size() == 0) begin
                    $display("bus request with no load outstanding");
                    proto_errors++;
                end else begin
                    exp_addr = addr_q.pop_front();
                    if (mem_addr !== exp_addr) begin
                        $display("[FAIL] mem_addr exp 0x%h got 0x%h", exp_addr, mem_addr);
                        proto_errors++;
                    end
                end
            end
            if (mem_req && prev_req && !prev_ack && (mem_addr !== prev_addr)) begin
                $display("[FAIL] mem_addr exp 0x%h got 0x%h", prev_addr, mem_addr);
                proto_errors++;
            end
            if (!mem_req && prev_req && !prev_ack) begin
                $display("mem_req dropped before mem_ack arrived");
                proto_errors++;
            end
            prev_req  = mem_req;
            prev_ack  = mem_ack;
            prev_addr = mem_addr;
        end
    end

endmodule

`default_nettype wire

/* test/pipe_tb.sv */
`default_nettype none

module pipe_tb;

    localparam logic [31:0] SEED         = 32'h7fd9ba0c;
    localparam int          ACCEPT_LIMIT = 200;   // cycles one uop may sit in decode
    localparam int          DRAIN_LIMIT  = 2000;
    localparam int          RANDOM_UOPS  = 400;

    logic               clk;
    logic               rst_n;
    pipe_pkg::uop_t     in_uop;
    logic               in_valid;
    logic               in_ready;
    logic               mem_req;
    pipe_pkg::word_t    mem_addr;
    logic               mem_ack;
    pipe_pkg::word_t    mem_rdata;
    logic               wb_valid;
    pipe_pkg::retire_t  wb;

    int          accepted;
    int          retired;
    int          value_errors;
    int          proto_errors;
    int          flow_errors;   // stalls, timeouts, counts
    int          sent;
    bit          aborted;       // set on timeout, later sends skipped
    logic [31:0] stim_lfsr;
    logic [31:0] bus_lfsr;      // own stream for the responder
    int          ack_wait;
    bit          armed;

    always #4 clk = ~clk;

    pipe_top UUT (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_uop    (in_uop),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .mem_req   (mem_req),
        .mem_addr  (mem_addr),
        .mem_ack   (mem_ack),
        .mem_rdata (mem_rdata),
        .wb_valid  (wb_valid),
        .wb        (wb)
    );

    pipe_checker u_checker (
        .clk          (clk),
        .rst_n        (rst_n),
        .in_valid     (in_valid),
        .in_ready     (in_ready),
        .in_uop       (in_uop),
        .mem_req      (mem_req),
        .mem_addr     (mem_addr),
        .mem_ack      (mem_ack),
        .wb_valid     (wb_valid),
        .wb           (wb),
        .accepted     (accepted),
        .retired      (retired),
        .value_errors (value_errors),
        .proto_errors (proto_errors)
    );

    // fibonacci, taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        lfsr_next = {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic stim_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            stim_lfsr = lfsr_next(stim_lfsr);
            v = {v[30:0], stim_lfsr[0]};  // one step per bit
        end
    endtask

    function automatic pipe_pkg::uop_t make_uop(
        input pipe_pkg::alu_op_t  op,
        input pipe_pkg::reg_idx_t rd,
        input pipe_pkg::reg_idx_t rs1,
        input pipe_pkg::reg_idx_t rs2,
        input logic               use_imm,
        input pipe_pkg::word_t    imm
    );
        make_uop.op      = op;
        make_uop.rd      = rd;
        make_uop.rs1     = rs1;
        make_uop.rs2     = rs2;
        make_uop.use_imm = use_imm;
        make_uop.imm     = imm;
    endfunction

    // mostly x1..x4 so hazards show up often
    task automatic pick_reg(output pipe_pkg::reg_idx_t idx);
        logic [31:0] r;
        stim_bits(3, r);
        if (r[2:0] < 3'd6) begin
            idx = 4'd1 + r[1:0];
        end else begin
            stim_bits(4, r);
            idx = r[3:0];
        end
    endtask

    task automatic random_uop(output pipe_pkg::uop_t u);
        logic [31:0]        r;
        logic [31:0]        imm;
        logic               use_imm;
        pipe_pkg::alu_op_t  op;
        pipe_pkg::reg_idx_t rd;
        pipe_pkg::reg_idx_t rs1;
        pipe_pkg::reg_idx_t rs2;
        stim_bits(3, r);
        op = (r[2:0] == 3'd7) ? pipe_pkg::OP_LOAD : pipe_pkg::alu_op_t'(r[2:0]);  // 6 and 7 load
        pick_reg(rd);
        pick_reg(rs1);
        pick_reg(rs2);
        stim_bits(1, r);
        use_imm = r[0];
        stim_bits(32, imm);
        u = make_uop(op, rd, rs1, rs2, use_imm, imm);
    endtask

    // drive on falling edge, hold until the rising edge that takes it
    task automatic send_uop(input pipe_pkg::uop_t u, output int waited);
        bit done;
        int guard;
        waited = 0;
        if (aborted) return;
        @(negedge clk);
        in_uop   = u;
        in_valid = 1'b1;
        done     = 1'b0;
        guard    = 0;
        while (!done) begin
            @(posedge clk);
            if (in_ready) begin
                done = 1'b1;
            end else begin
                waited++;
                guard++;
                if (guard > ACCEPT_LIMIT) begin
                    $display("timeout: micro-op not accepted within %0d cycles", ACCEPT_LIMIT);
                    flow_errors++;
                    aborted = 1'b1;
                    done    = 1'b1;
                end
            end
        end
        if (!aborted) sent++;
    endtask

    task automatic idle(input int n);
        repeat (n) begin
            @(negedge clk);
            in_valid = 1'b0;
        end
    endtask

    task automatic drain_pipe();
        int guard;
        guard = 0;
        if (aborted) return;
        while (retired < sent) begin
            @(negedge clk);
            guard++;
            if (guard > DRAIN_LIMIT) begin
                $display("timeout: only %0d of %0d micro-ops retired", retired, sent);
                flow_errors++;
                aborted = 1'b1;
                break;
            end
        end
        repeat (4) @(negedge clk);  // catch stray writebacks
    endtask

    // bus slave with random ack delay, data is the inverted address
    always @(negedge clk) begin : bus_responder
        if (!rst_n) begin
            armed    = 1'b0;
            ack_wait = 0;
            mem_ack  = 1'b0;
        end else if (mem_ack) begin
            if (!mem_req) begin
                mem_ack = 1'b0;  // phase 4
            end
        end else if (mem_req) begin
            if (!armed) begin
                ack_wait = 0;
                for (int i = 0; i < 3; i++) begin
                    bus_lfsr = lfsr_next(bus_lfsr);
                    ack_wait = (ack_wait << 1) | bus_lfsr[0];
                end
                armed = 1'b1;
            end
            if (ack_wait == 0) begin
                mem_ack   = 1'b1;
                mem_rdata = ~mem_addr;
                armed     = 1'b0;
            end else begin
                ack_wait--;
            end
        end
    end

    initial begin
        pipe_pkg::uop_t u;
        pipe_pkg::uop_t chain [6];
        int             waited;
        int             stalls;
        clk         = 1'b0;
        rst_n       = 1'b0;
        in_valid    = 1'b0;
        in_uop      = '0;
        mem_ack     = 1'b0;
        mem_rdata   = '0;
        stim_lfsr   = SEED;
        bus_lfsr    = SEED;
        flow_errors = 0;
        sent        = 0;
        aborted     = 1'b0;
        repeat (16) @(posedge clk);
        @(negedge clk);
        if (in_ready || mem_req || wb_valid) begin
            $display("in_ready, mem_req or wb_valid high during reset");
            flow_errors++;
        end
        rst_n = 1'b1;

        // independent immediates, checker times each one
        for (int i = 1; i <= 4; i++) begin
            send_uop(make_uop(pipe_pkg::OP_ADD, i, 0, 0, 1'b1, 32'h1000 * i + 7), waited);
        end
        idle(3);
        for (int i = 0; i < 6; i++) begin
            u = make_uop(pipe_pkg::alu_op_t'(i), 5 + i, 1 + (i % 4), 0, 1'b1, 32'h0f0f_0003 + i);
            send_uop(u, waited);
        end
        idle(3);

        // dependent chain, EX and MEM forwarding plus write-through
        chain[0] = make_uop(pipe_pkg::OP_ADD, 1, 0, 0, 1'b1, 32'h11);
        chain[1] = make_uop(pipe_pkg::OP_ADD, 2, 1, 1, 1'b0, '0);
        chain[2] = make_uop(pipe_pkg::OP_SUB, 3, 2, 1, 1'b0, '0);
        chain[3] = make_uop(pipe_pkg::OP_XOR, 4, 3, 1, 1'b0, '0);
        chain[4] = make_uop(pipe_pkg::OP_SLL, 1, 4, 2, 1'b0, '0);
        chain[5] = make_uop(pipe_pkg::OP_OR,  2, 1, 0, 1'b1, 32'hf0);
        for (int i = 0; i < 6; i++) begin
            send_uop(chain[i], waited);
            if (waited != 0) begin
                $display("dependent ALU micro-op %0d stalled %0d cycles", i, waited);
                flow_errors++;
            end
        end
        idle(3);

        // x0 stays zero whatever is written to it
        send_uop(make_uop(pipe_pkg::OP_ADD,  0, 1, 0, 1'b1, 32'h1234), waited);
        send_uop(make_uop(pipe_pkg::OP_OR,   7, 0, 0, 1'b0, '0), waited);
        send_uop(make_uop(pipe_pkg::OP_ADD,  8, 0, 0, 1'b1, 32'h5), waited);
        send_uop(make_uop(pipe_pkg::OP_LOAD, 0, 0, 0, 1'b1, 32'h40), waited);
        send_uop(make_uop(pipe_pkg::OP_ADD,  9, 0, 0, 1'b0, '0), waited);
        idle(3);

        // load-use directly behind, then a use against a busy load in MEM
        send_uop(make_uop(pipe_pkg::OP_LOAD, 5, 1, 0, 1'b1, 32'h200), waited);
        send_uop(make_uop(pipe_pkg::OP_ADD,  6, 5, 0, 1'b1, 32'h1), waited);
        if (waited == 0 && !aborted) begin
            $display("load-use conflict did not stall decode");
            flow_errors++;
        end
        send_uop(make_uop(pipe_pkg::OP_LOAD, 10, 2, 3, 1'b0, '0), waited);
        send_uop(make_uop(pipe_pkg::OP_ADD,  11, 0, 0, 1'b1, 32'h7), waited);
        send_uop(make_uop(pipe_pkg::OP_XOR,  12, 10, 11, 1'b0, '0), waited);
        idle(3);

        // back-to-back loads against the slow bus
        stalls = 0;
        for (int i = 0; i < 6; i++) begin
            u = make_uop(pipe_pkg::OP_LOAD, 1 + (i % 3), 1 + ((i + 1) % 3), 0, 1'b1, 4 * i);
            send_uop(u, waited);
            stalls += waited;
        end
        if (stalls == 0 && !aborted) begin
            $display("in_ready never dropped during back-to-back loads");
            flow_errors++;
        end

        // long random mix with the odd idle cycle
        for (int n = 0; n < RANDOM_UOPS; n++) begin
            logic [31:0] r;
            random_uop(u);
            send_uop(u, waited);
            stim_bits(2, r);
            if (r[1:0] == 2'd0) idle(1);
        end
        idle(1);
        drain_pipe();

        if (!aborted && (retired != sent || accepted != sent)) begin
            $display("sent %0d, accepted %0d, retired %0d micro-ops", sent, accepted, retired);
            flow_errors++;
        end
        $display("errors: value %0d, protocol %0d, flow %0d; retired %0d of %0d",
                 value_errors, proto_errors, flow_errors, retired, sent);
        if (value_errors + proto_errors + flow_errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* project.f */
+incdir+src
src/pipe_pkg.sv
src/hazard_unit.sv
src/pipe_control.sv
src/operand_fetch.sv
src/exec_alu.sv
src/load_port.sv
src/pipe_top.sv
test/pipe_checker.sv
test/pipe_tb.sv
